/* all.f */
+incdir+.
pkt_gen_pkg.sv
pkt_mem_ram.sv
pkt_gen_mem_wrap.sv
pkt_mem_loader.sv
pkt_gen_seq.sv
pkt_gen_top.sv
tb_pkt_gen.sv

/* pkt_gen_mem_wrap.sv */
// packet memory, data and control banks sized for the active rate
// unused upper lanes read back as idle, read data registered once more
`timescale 1ns/1ns

module pkt_gen_mem_wrap (
    input  logic                                 clk,
    input  logic                                 arst_n,
    // write side
    input  logic                                 mem_wr,
    input  logic [pkt_gen_pkg::addr_w-1:0]       mem_addr,
    input  logic [pkt_gen_pkg::word_w-1:0]       mem_data,
    input  logic [pkt_gen_pkg::lanes_max-1:0]    mem_ctl,
    input  logic                                 mem_sop,
    input  logic                                 mem_term,
    // read side
    input  logic                                 rd_en,
    input  logic [pkt_gen_pkg::addr_w-1:0]       rd_addr,
    output logic [pkt_gen_pkg::word_w-1:0]       rd_data,
    output logic [pkt_gen_pkg::lanes_max-1:0]    rd_ctl,
    output logic                                 rd_sop,
    output logic                                 rd_term
);

    localparam int lw = pkt_gen_pkg::lane_w;
    localparam int la = pkt_gen_pkg::lanes_active;

    logic [pkt_gen_pkg::data_w-1:0]    bank_data;
    logic [pkt_gen_pkg::ctl_w-1:0]     bank_ctl;    // {sop, term, lane ctl}
    logic [pkt_gen_pkg::word_w-1:0]    fill_data;
    logic [pkt_gen_pkg::lanes_max-1:0] fill_ctl;
    logic                              ram_vld;     // ram output holds a fresh read

    // --------------------------------------------------
    // banks, only the low active lanes are stored
    // --------------------------------------------------
    pkt_mem_ram #(
        .width (pkt_gen_pkg::data_w),
        .depth (pkt_gen_pkg::mem_depth)
    ) u_data_bank (
        .clk     (clk),
        .wr_en   (mem_wr),
        .wr_addr (mem_addr),
        .wr_data (mem_data[pkt_gen_pkg::data_w-1:0]),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (bank_data)
    );

    pkt_mem_ram #(
        .width (pkt_gen_pkg::ctl_w),
        .depth (pkt_gen_pkg::mem_depth)
    ) u_ctl_bank (
        .clk     (clk),
        .wr_en   (mem_wr),
        .wr_addr (mem_addr),
        .wr_data ({mem_sop, mem_term, mem_ctl[la-1:0]}),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (bank_ctl)
    );

    // idle fill above the active width
    for (genvar i = 0; i < pkt_gen_pkg::lanes_max; i++) begin : g_lane
        if (i < la) begin : g_used
            assign fill_data[i*lw +: lw] = bank_data[i*lw +: lw];
            assign fill_ctl[i]           = bank_ctl[i];
        end else begin : g_idle
            assign fill_data[i*lw +: lw] = pkt_gen_pkg::idle_data;
            assign fill_ctl[i]           = pkt_gen_pkg::idle_ctl;
        end
    end

    // --------------------------------------------------
    // output register
    // --------------------------------------------------
    // ram output holds its last word, so flags only pass on a fresh read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ram_vld <= 1'b0;
            rd_sop  <= 1'b0;
            rd_term <= 1'b0;
        end else begin
            ram_vld <= rd_en;
            rd_sop  <= ram_vld & bank_ctl[pkt_gen_pkg::ctl_w-1];
            rd_term <= ram_vld & bank_ctl[pkt_gen_pkg::ctl_w-2];
        end
    end

    always_ff @(posedge clk) begin
        if (ram_vld) begin
            rd_data <= fill_data;
            rd_ctl  <= fill_ctl;
        end
    end

    // flags only follow a read issued two cycles before
    a_flags_need_read : assert property (@(posedge clk) disable iff (!arst_n)
        !$past(rd_en, pkt_gen_pkg::rd_latency) |-> !rd_sop && !rd_term)
        else $error("sop/term without a matching read");

endmodule

/* pkt_gen_pkg.sv */
// shared geometry, rate code and encodings for the packet generator memory
// referenced by scoped name from the RTL and the testbench
package pkt_gen_pkg;

    // --------------------------------------------------
    // memory geometry
    // --------------------------------------------------
    localparam int mem_depth = 64;              // packet entries
    localparam int addr_w    = 6;

    // full output word, lane i in bits 8i+7:8i
    localparam int lanes_max = 8;
    localparam int lane_w    = 8;
    localparam int word_w    = lanes_max * lane_w;

    // --------------------------------------------------
    // rate dependent bank widths
    // --------------------------------------------------
    // rate code 0,1,2,3 stores 1,2,4,8 lanes
    localparam int rate_op      = 2;
    localparam int lanes_active = 1 << rate_op;

    localparam int data_w = lanes_active * lane_w;
    localparam int ctl_w  = lanes_active + 2;   // lane ctl bits + sop + term

    // pcs idle, used to fill lanes above the active width
    localparam logic [7:0] idle_data = 8'h07;
    localparam logic       idle_ctl  = 1'b1;

    // read issued to data at the wrapper output
    // one cycle in the ram, one in the wrapper output register
    localparam int rd_latency = 2;

    // --------------------------------------------------
    // FSM state codes
    // --------------------------------------------------
    // host write handshake
    localparam logic [1:0] ld_idle  = 2'd0;
    localparam logic [1:0] ld_write = 2'd1;
    localparam logic [1:0] ld_ack   = 2'd2;

    // read sequencer
    localparam logic [1:0] seq_idle = 2'd0;
    localparam logic [1:0] seq_run  = 2'd1;
    localparam logic [1:0] seq_stop = 2'd2;   // gen_en gone, finishing pass

endpackage

/* pkt_gen_seq.sv */
// read-address sequencer, plays entries from 0 to the terminate entry and wraps
// tracks the two in-flight reads and drops the ones issued past terminate
`timescale 1ns/1ns

module pkt_gen_seq (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              gen_en,
    // to / from the memory wrapper
    output logic                              rd_en,
    output logic [pkt_gen_pkg::addr_w-1:0]    rd_addr,
    input  logic [pkt_gen_pkg::word_w-1:0]    rd_data,
    input  logic [pkt_gen_pkg::lanes_max-1:0] rd_ctl,
    input  logic                              rd_sop,
    input  logic                              rd_term,
    // generated stream, no back-pressure
    output logic                              gen_valid,
    output logic [pkt_gen_pkg::word_w-1:0]    gen_data,
    output logic [pkt_gen_pkg::lanes_max-1:0] gen_ctl,
    output logic                              gen_sop,
    output logic                              gen_term,
    output logic                              gen_busy
);

    logic [1:0] state;
    logic [1:0] vld_q;       // in-flight reads, [1] lines up with rd_data
    logic [1:0] flush_cnt;
    logic       flush;
    logic       term_seen;

    assign rd_en     = (state != pkt_gen_pkg::seq_idle);   // one read per cycle
    assign term_seen = vld_q[1] & rd_term;
    assign flush     = (flush_cnt != 2'd0);

    // --------------------------------------------------
    // address counter, in-flight pipe, run/stop
    // --------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= pkt_gen_pkg::seq_idle;
            rd_addr   <= '0;
            vld_q     <= '0;
            flush_cnt <= '0;
        end else begin
            vld_q <= {vld_q[0], rd_en};
            if (flush) begin
                flush_cnt <= flush_cnt - 2'd1;
            end

            if (state == pkt_gen_pkg::seq_idle) begin
                if (gen_en) begin
                    state <= pkt_gen_pkg::seq_run;
                end
            end else if (term_seen) begin
                // wrap, reads past terminate are dropped
                rd_addr   <= '0;
                vld_q     <= '0;
                flush_cnt <= 2'(pkt_gen_pkg::rd_latency);
                state     <= gen_en ? pkt_gen_pkg::seq_run : pkt_gen_pkg::seq_idle;
            end else begin
                rd_addr <= rd_addr + 1'b1;
                // stop waits for this pass's terminate
                state   <= gen_en ? pkt_gen_pkg::seq_run : pkt_gen_pkg::seq_stop;
            end
        end
    end

    assign gen_valid = vld_q[1];
    assign gen_data  = rd_data;
    assign gen_ctl   = rd_ctl;
    assign gen_sop   = vld_q[1] & rd_sop;
    assign gen_term  = term_seen;
    assign gen_busy  = (state != pkt_gen_pkg::seq_idle) | flush;   // includes drain

    a_no_valid_in_flush : assert property (@(posedge clk) disable iff (!arst_n)
        flush |-> !gen_valid)
        else $error("valid beat during flush");

endmodule

/* pkt_gen_top.sv */
// packet generator memory top, host loader + banked memory + read sequencer
`timescale 1ns/1ns

module pkt_gen_top (
    input  logic                              clk,
    input  logic                              arst_n,
    // host write port
    input  logic                              wr_req,
    input  logic [pkt_gen_pkg::addr_w-1:0]    wr_addr,
    input  logic [pkt_gen_pkg::word_w-1:0]    wr_data,
    input  logic [pkt_gen_pkg::lanes_max-1:0] wr_ctl,
    input  logic                              wr_sop,
    input  logic                              wr_term,
    output logic                              wr_ack,
    // generation control and stream
    input  logic                              gen_en,
    output logic                              gen_valid,
    output logic [pkt_gen_pkg::word_w-1:0]    gen_data,
    output logic [pkt_gen_pkg::lanes_max-1:0] gen_ctl,
    output logic                              gen_sop,
    output logic                              gen_term,
    output logic                              gen_busy
);

    logic                              mem_wr;
    logic [pkt_gen_pkg::addr_w-1:0]    mem_addr;
    logic [pkt_gen_pkg::word_w-1:0]    mem_data;
    logic [pkt_gen_pkg::lanes_max-1:0] mem_ctl;
    logic                              mem_sop;
    logic                              mem_term;

    logic                              rd_en;
    logic [pkt_gen_pkg::addr_w-1:0]    rd_addr;
    logic [pkt_gen_pkg::word_w-1:0]    rd_data;
    logic [pkt_gen_pkg::lanes_max-1:0] rd_ctl;
    logic                              rd_sop;
    logic                              rd_term;

    pkt_mem_loader u_pkt_mem_loader (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_req   (wr_req),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_ctl   (wr_ctl),
        .wr_sop   (wr_sop),
        .wr_term  (wr_term),
        .wr_ack   (wr_ack),
        .mem_wr   (mem_wr),
        .mem_addr (mem_addr),
        .mem_data (mem_data),
        .mem_ctl  (mem_ctl),
        .mem_sop  (mem_sop),
        .mem_term (mem_term)
    );

    pkt_gen_mem_wrap u_pkt_gen_mem_wrap (
        .clk      (clk),
        .arst_n   (arst_n),
        .mem_wr   (mem_wr),
        .mem_addr (mem_addr),
        .mem_data (mem_data),
        .mem_ctl  (mem_ctl),
        .mem_sop  (mem_sop),
        .mem_term (mem_term),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .rd_ctl   (rd_ctl),
        .rd_sop   (rd_sop),
        .rd_term  (rd_term)
    );

    pkt_gen_seq u_pkt_gen_seq (
        .clk       (clk),
        .arst_n    (arst_n),
        .gen_en    (gen_en),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .rd_ctl    (rd_ctl),
        .rd_sop    (rd_sop),
        .rd_term   (rd_term),
        .gen_valid (gen_valid),
        .gen_data  (gen_data),
        .gen_ctl   (gen_ctl),
        .gen_sop   (gen_sop),
        .gen_term  (gen_term),
        .gen_busy  (gen_busy)
    );

endmodule

/* pkt_mem_loader.sv */
// host write port, four-phase req/ack handshake
// each request becomes exactly one memory write pulse
`timescale 1ns/1ns

module pkt_mem_loader (
    input  logic                              clk,
    input  logic                              arst_n,
    // host side
    input  logic                              wr_req,
    input  logic [pkt_gen_pkg::addr_w-1:0]    wr_addr,
    input  logic [pkt_gen_pkg::word_w-1:0]    wr_data,
    input  logic [pkt_gen_pkg::lanes_max-1:0] wr_ctl,
    input  logic                              wr_sop,
    input  logic                              wr_term,
    output logic                              wr_ack,
    // memory side
    output logic                              mem_wr,
    output logic [pkt_gen_pkg::addr_w-1:0]    mem_addr,
    output logic [pkt_gen_pkg::word_w-1:0]    mem_data,
    output logic [pkt_gen_pkg::lanes_max-1:0] mem_ctl,
    output logic                              mem_sop,
    output logic                              mem_term
);

    logic [1:0] state;

    // --------------------------------------------------
    // handshake FSM
    // --------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= pkt_gen_pkg::ld_idle;
            wr_ack <= 1'b0;
            mem_wr <= 1'b0;
        end else begin
            mem_wr <= 1'b0;   // single cycle pulse
            case (state)
                pkt_gen_pkg::ld_idle: begin
                    if (wr_req) begin
                        mem_wr <= 1'b1;
                        state  <= pkt_gen_pkg::ld_write;
                    end
                end
                pkt_gen_pkg::ld_write: state <= pkt_gen_pkg::ld_ack;   // ram takes the word
                pkt_gen_pkg::ld_ack: begin
                    if (!wr_ack) begin
                        wr_ack <= 1'b1;
                    end else if (!wr_req) begin
                        wr_ack <= 1'b0;
                        state  <= pkt_gen_pkg::ld_idle;
                    end
                end
                default: state <= pkt_gen_pkg::ld_idle;
            endcase
        end
    end

    // fields captured once, host holds them until ack anyway
    always_ff @(posedge clk) begin
        if (state == pkt_gen_pkg::ld_idle && wr_req) begin
            mem_addr <= wr_addr;
            mem_data <= wr_data;
            mem_ctl  <= wr_ctl;
            mem_sop  <= wr_sop;
            mem_term <= wr_term;
        end
    end

    // req must be high at the edge that raises ack, the host may drop it right after
    a_ack_after_req : assert property (@(posedge clk) disable iff (!arst_n)
        $rose(wr_ack) |-> $past(wr_req))
        else $error("wr_ack rose without wr_req");

endmodule

/* pkt_mem_ram.sv */
// simple dual-port ram, one write and one registered read port
// width and depth set per instance
`timescale 1ns/1ns

module pkt_mem_ram #(
    parameter int width = 8,
    parameter int depth = 64
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(depth)-1:0] wr_addr,
    input  logic [width-1:0]         wr_data,
    input  logic                     rd_en,
    input  logic [$clog2(depth)-1:0] rd_addr,
    output logic [width-1:0]         rd_data
);

    logic [width-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        // same-address collision returns the old word
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // addresses must be known whenever their port is in use
    a_wr_addr_known : assert property (@(posedge clk) wr_en |-> !$isunknown(wr_addr))
        else $error("ram write address unknown");
    a_rd_addr_known : assert property (@(posedge clk) rd_en |-> !$isunknown(rd_addr))
        else $error("ram read address unknown");

endmodule

/* tb_pkt_gen_table.svh */
// packet table for the testbench, one row per host write in address order
// rows after the terminate row are stored in memory but must never be played
`ifndef TB_PKT_GEN_TABLE_SVH
`define TB_PKT_GEN_TABLE_SVH

localparam int pkt_len = 5;   // entries from sop through terminate

logic [pkt_gen_pkg::addr_w-1:0]    tbl_addr [$];
logic [pkt_gen_pkg::word_w-1:0]    tbl_data [$];
logic [pkt_gen_pkg::lanes_max-1:0] tbl_ctl  [$];
logic                              tbl_sop  [$];
logic                              tbl_term [$];

task automatic add_row(input logic [pkt_gen_pkg::addr_w-1:0] addr,
                       input logic [pkt_gen_pkg::word_w-1:0] data,
                       input logic [pkt_gen_pkg::lanes_max-1:0] ctl,
                       input logic sop, input logic term);
    tbl_addr.push_back(addr);
    tbl_data.push_back(data);
    tbl_ctl.push_back(ctl);
    tbl_sop.push_back(sop);
    tbl_term.push_back(term);
endtask

task automatic fill_table();
    //      addr  data                    ctl    sop   term
    add_row(6'd0, 64'hdead_beef_0302_01fb, 8'h01, 1'b1, 1'b0);   // start char on lane 0
    add_row(6'd1, 64'h5555_5555_1716_1514, 8'h00, 1'b0, 1'b0);
    add_row(6'd2, 64'h0f0f_0f0f_2726_2524, 8'h00, 1'b0, 1'b0);
    add_row(6'd3, 64'h1234_5678_3736_3534, 8'h00, 1'b0, 1'b0);
    add_row(6'd4, 64'h9999_9999_0707_fd44, 8'h0e, 1'b0, 1'b1);   // terminate on lane 1
    // markers past terminate
    add_row(6'd5, 64'hc5c5_c5c5_c5c5_c5c5, 8'h00, 1'b0, 1'b0);
    add_row(6'd6, 64'hc6c6_c6c6_c6c6_c6c6, 8'h00, 1'b0, 1'b0);
    add_row(6'd7, 64'hc7c7_c7c7_c7c7_c7c7, 8'h00, 1'b0, 1'b0);
endtask

// lanes at or above lanes_active come back as idle bytes
function automatic logic [pkt_gen_pkg::word_w-1:0] idle_fill_data(
        input logic [pkt_gen_pkg::word_w-1:0] d);
    logic [pkt_gen_pkg::word_w-1:0] r;
    r = d;
    for (int i = pkt_gen_pkg::lanes_active; i < pkt_gen_pkg::lanes_max; i++) begin
        r[i*pkt_gen_pkg::lane_w +: pkt_gen_pkg::lane_w] = 8'h07;
    end
    return r;
endfunction

function automatic logic [pkt_gen_pkg::lanes_max-1:0] idle_fill_ctl(
        input logic [pkt_gen_pkg::lanes_max-1:0] c);
    logic [pkt_gen_pkg::lanes_max-1:0] r;
    r = c;
    for (int i = pkt_gen_pkg::lanes_active; i < pkt_gen_pkg::lanes_max; i++) begin
        r[i] = 1'b1;   // idle is a control character
    end
    return r;
endfunction

`endif

/* tb_pkt_gen.sv */
// testbench for the packet generator memory, loads a packet table over the host port
// and checks the played stream, wrap, stop and overwrite; top module tb_pkt_gen
`timescale 1ns/1ns

module tb_pkt_gen;

    localparam int clk_period = 10;

    logic                              clk;
    logic                              arst_n;
    logic                              wr_req;
    logic [pkt_gen_pkg::addr_w-1:0]    wr_addr;
    logic [pkt_gen_pkg::word_w-1:0]    wr_data;
    logic [pkt_gen_pkg::lanes_max-1:0] wr_ctl;
    logic                              wr_sop;
    logic                              wr_term;
    logic                              wr_ack;
    logic                              gen_en;
    logic                              gen_valid;
    logic [pkt_gen_pkg::word_w-1:0]    gen_data;
    logic [pkt_gen_pkg::lanes_max-1:0] gen_ctl;
    logic                              gen_sop;
    logic                              gen_term;
    logic                              gen_busy;

    int   err_count;
    int   check_count;
    int   test_count;
    int   fail_count;
    int   test_errs;     // err_count when the current test began
    int   term_row;      // table row that ends the packet
    bit   table_ready;
    logic ack_q;
    logic req_q;

    // valid beats seen on the stream
    logic [pkt_gen_pkg::word_w-1:0]    beat_data [$];
    logic [pkt_gen_pkg::lanes_max-1:0] beat_ctl  [$];
    logic                              beat_sop  [$];
    logic                              beat_term [$];
    time                               beat_time [$];

    // one expected pass, idle fill applied
    logic [pkt_gen_pkg::word_w-1:0]    exp_data [$];
    logic [pkt_gen_pkg::lanes_max-1:0] exp_ctl  [$];
    logic                              exp_sop  [$];
    logic                              exp_term [$];

    `include "tb_pkt_gen_table.svh"

    pkt_gen_top u_pkt_gen_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_ctl    (wr_ctl),
        .wr_sop    (wr_sop),
        .wr_term   (wr_term),
        .wr_ack    (wr_ack),
        .gen_en    (gen_en),
        .gen_valid (gen_valid),
        .gen_data  (gen_data),
        .gen_ctl   (gen_ctl),
        .gen_sop   (gen_sop),
        .gen_term  (gen_term),
        .gen_busy  (gen_busy)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // --------------------------------------------------
    // checking helpers
    // --------------------------------------------------
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("error at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        err_count++;
        $display("error at %0t ns: %s", $time, what);
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (err_count == test_errs) begin
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: %0d errors", name, err_count - test_errs);
        end
        test_errs = err_count;
    endtask

    // stream sampled before the edge updates it, handshake order watched too
    always @(posedge clk) begin
        if (gen_valid === 1'b1) begin
            beat_data.push_back(gen_data);
            beat_ctl.push_back(gen_ctl);
            beat_sop.push_back(gen_sop);
            beat_term.push_back(gen_term);
            beat_time.push_back($time);
        end
        if (arst_n === 1'b1 && wr_ack === 1'b1 && ack_q === 1'b0) begin
            check_value("wr_req at wr_ack rise", req_q, 1'b1);
        end
        if (arst_n === 1'b1 && wr_ack === 1'b0 && ack_q === 1'b1) begin
            check_value("wr_req at wr_ack fall", req_q, 1'b0);
        end
        ack_q <= wr_ack;
        req_q <= wr_req;
    end

    task automatic build_expected();
        term_row = tbl_addr.size();
        for (int i = 0; i < tbl_addr.size() && term_row == tbl_addr.size(); i++) begin
            exp_data.push_back(idle_fill_data(tbl_data[i]));
            exp_ctl.push_back(idle_fill_ctl(tbl_ctl[i]));
            exp_sop.push_back(tbl_sop[i]);
            exp_term.push_back(tbl_term[i]);
            if (tbl_term[i]) begin
                term_row = i;
            end
        end
    endtask

    // --------------------------------------------------
    // drivers and waits
    // --------------------------------------------------
    task automatic write_entry(input logic [pkt_gen_pkg::addr_w-1:0] addr,
                               input logic [pkt_gen_pkg::word_w-1:0] data,
                               input logic [pkt_gen_pkg::lanes_max-1:0] ctl,
                               input logic sop, input logic term);
        int n;
        @(negedge clk);
        check_value("wr_ack before wr_req", wr_ack, 1'b0);
        wr_addr = addr;
        wr_data = data;
        wr_ctl  = ctl;
        wr_sop  = sop;
        wr_term = term;
        wr_req  = 1'b1;   // fields held until ack
        n = 0;
        while (wr_ack !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (wr_ack !== 1'b1) begin
            report_failure("no wr_ack within 20 cycles of wr_req");
        end
        wr_req = 1'b0;
        n = 0;
        while (wr_ack !== 1'b0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (wr_ack !== 1'b0) begin
            report_failure("wr_ack stayed high after wr_req fell");
        end
    endtask

    task automatic clear_beats();
        beat_data.delete();
        beat_ctl.delete();
        beat_sop.delete();
        beat_term.delete();
        beat_time.delete();
    endtask

    task automatic wait_beats(input int n, input int max_cycles);
        int c;
        c = 0;
        while (beat_data.size() < n && c < max_cycles) begin
            @(negedge clk);
            c++;
        end
        if (beat_data.size() < n) begin
            report_failure($sformatf("only %0d of %0d stream beats arrived",
                                     beat_data.size(), n));
        end
    endtask

    task automatic wait_idle(input int max_cycles);
        int c;
        c = 0;
        while (gen_busy !== 1'b0 && c < max_cycles) begin
            @(negedge clk);
            c++;
        end
        if (gen_busy !== 1'b0) begin
            report_failure("generator did not go idle after gen_en fell");
        end
    endtask

    // beats first_beat.. against the expected pass starting at entry first_exp
    task automatic check_beats(input int first_beat, input int n, input int first_exp);
        int b;
        int e;
        int cnt;
        cnt = n;
        if (first_beat + n > beat_data.size()) begin
            report_failure("stream ended before all expected beats");
            cnt = beat_data.size() - first_beat;
        end
        for (int k = 0; k < cnt; k++) begin
            b = first_beat + k;
            e = (first_exp + k) % exp_data.size();
            check_value($sformatf("gen_data beat %0d", b), beat_data[b], exp_data[e]);
            check_value($sformatf("gen_ctl beat %0d", b), beat_ctl[b], exp_ctl[e]);
            check_value($sformatf("gen_sop beat %0d", b), beat_sop[b], exp_sop[e]);
            check_value($sformatf("gen_term beat %0d", b), beat_term[b], exp_term[e]);
        end
    endtask

    task automatic check_no_markers();
        for (int b = 0; b < beat_data.size(); b++) begin
            for (int r = term_row + 1; r < tbl_data.size(); r++) begin
                if (beat_data[b] === idle_fill_data(tbl_data[r])) begin
                    report_failure($sformatf("entry at address %0d past terminate was played",
                                             tbl_addr[r]));
                end
            end
        end
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        int c;
        int drop_at;
        int n;
        logic [pkt_gen_pkg::word_w-1:0] rnd;
        void'($urandom(32'h07f0aa39));
        wr_req  = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        wr_ctl  = '0;
        wr_sop  = 1'b0;
        wr_term = 1'b0;
        gen_en  = 1'b0;
        arst_n  = 1'b0;
        fill_table();
        build_expected();
        table_ready = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        repeat (20) begin
            @(negedge clk);
            check_value("wr_ack", wr_ack, 1'b0);
            check_value("gen_valid", gen_valid, 1'b0);
            check_value("gen_busy", gen_busy, 1'b0);
        end
        end_test("reset");

        for (int i = 0; i < tbl_addr.size(); i++) begin
            write_entry(tbl_addr[i], tbl_data[i], tbl_ctl[i], tbl_sop[i], tbl_term[i]);
        end
        end_test("handshake");

        clear_beats();
        @(negedge clk);
        gen_en = 1'b1;
        wait_beats(3 * exp_data.size() + 1, 100);
        check_beats(0, exp_data.size(), 0);
        end_test("stream");

        check_beats(exp_data.size(), 2 * exp_data.size(), 0);
        for (int b = 0; b + 1 < beat_data.size(); b++) begin
            if (beat_term[b]) begin   // valid low for rd_latency cycles at the wrap
                check_value("cycles between terminate and next sop (ns)",
                            beat_time[b+1] - beat_time[b],
                            (pkt_gen_pkg::rd_latency + 1) * clk_period);
            end
        end
        check_no_markers();
        end_test("looping");

        // drop gen_en once entry 1 of a pass is out
        clear_beats();
        c = 0;
        while (!(beat_sop.size() >= 2 && beat_sop[beat_sop.size()-2]) && c < 100) begin
            @(negedge clk);
            c++;
        end
        if (c >= 100) begin
            report_failure("no sop beat seen before stopping");
        end
        gen_en = 1'b0;
        drop_at = beat_data.size();
        wait_idle(100);
        check_value("beats after gen_en fell", beat_data.size() - drop_at,
                    exp_data.size() - 2);
        check_beats(drop_at, exp_data.size() - 2, 2);
        if (beat_data.size() > 0) begin
            check_value("gen_term on last beat", beat_term[beat_data.size()-1], 1'b1);
        end
        n = beat_data.size();
        repeat (40) @(negedge clk);
        check_value("beats while gen_en low", beat_data.size(), n);
        end_test("stopping");

        for (int i = 0; i < pkt_len; i++) begin
            rnd = {$urandom, $urandom};
            write_entry(tbl_addr[i], rnd, tbl_ctl[i], tbl_sop[i], tbl_term[i]);
            exp_data[i] = idle_fill_data(rnd);
        end
        clear_beats();
        @(negedge clk);
        gen_en = 1'b1;
        wait_beats(2 * exp_data.size(), 100);
        gen_en = 1'b0;
        wait_idle(100);
        check_beats(0, 2 * exp_data.size(), 0);
        check_no_markers();
        end_test("restart");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, fail_count, check_count, err_count);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // budget of 8 cycles per host write plus a fixed margin
    initial begin
        wait (table_ready);
        repeat ((tbl_addr.size() + pkt_len) * 8 + 2000) @(posedge clk);
        $display("error at %0t ns: watchdog expired before the tests finished", $time);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
